//--- verilog/fetch_pkg.sv
package fetch_pkg;

  localparam int num_super = 2;  // buffer logic assumes a pair
  localparam int addr_w = 64;
  localparam int inst_w = 32;

  localparam logic [inst_w-1:0] noop_inst = 32'h47ff041f;
  localparam logic [addr_w-1:0] poison_pc = 64'hbaadbeefdeadbeef;

  // branch view of an instruction word
  typedef struct packed {
    logic [5:0]         opcode;
    logic [4:0]         ra;
    logic signed [20:0] disp;  // word displacement
  } branch_fmt_t;

  function automatic logic is_cond_branch(logic [5:0] opcode);
    return opcode[5:3] == 3'b111;  // 0x38 to 0x3f
  endfunction

  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] npc;
    logic [addr_w-1:0] target;
    logic [inst_w-1:0] inst;
    logic              valid;
  } fetch_entry_t;

  typedef struct packed {
    logic [num_super-1:0][addr_w-1:0] pc;
    logic [num_super-1:0][addr_w-1:0] npc;
    logic [num_super-1:0][addr_w-1:0] target;
    logic [num_super-1:0][inst_w-1:0] inst;
    logic [num_super-1:0]             valid;
  } fetch_pair_t;

  typedef struct packed {
    logic [num_super-1:0][addr_w-1:0] pc;
    logic [num_super-1:0][addr_w-1:0] npc;
    logic [num_super-1:0][inst_w-1:0] inst;
    logic [num_super-1:0][addr_w-1:0] target;
    logic                             valid;
  } fb_decoder_out_t;

endpackage

//--- verilog/inst_mem.sv
`timescale 1ns/10ps

module inst_mem #(
  parameter int mem_words = 256
) (
  input  logic                                                   clock,
  input  logic                                                   load,
  input  logic [$clog2(mem_words)-1:0]                           load_addr,
  input  logic [fetch_pkg::inst_w-1:0]                           load_data,
  input  logic [fetch_pkg::addr_w-1:0]                           pair_addr,
  output logic [fetch_pkg::num_super-1:0][fetch_pkg::inst_w-1:0] rd_data
);

  localparam int idx_w = $clog2(mem_words);

  logic [fetch_pkg::inst_w-1:0] mem [mem_words];
  logic [idx_w-2:0]             pair_idx;

  // pair index, wraps with the depth
  assign pair_idx = pair_addr[idx_w+1:3];

  always_ff @(posedge clock) begin
    if (load) begin
      mem[load_addr] <= load_data;
    end
  end

  // even word in slot 0, odd word in slot 1
  assign rd_data[0] = mem[{pair_idx, 1'b0}];
  assign rd_data[1] = mem[{pair_idx, 1'b1}];

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage #(
  parameter logic [fetch_pkg::addr_w-1:0] reset_pc = '0
) (
  input  logic                                                   clock,
  input  logic                                                   rst,
  input  logic                                                   redirect,
  input  logic [fetch_pkg::addr_w-1:0]                           redirect_pc,
  input  logic                                                   fetch_en,
  input  logic [fetch_pkg::num_super-1:0][fetch_pkg::inst_w-1:0] rd_data,
  output logic [fetch_pkg::addr_w-1:0]                           pair_addr,
  output fetch_pkg::fetch_pair_t                                 pair
);

  localparam int aw = fetch_pkg::addr_w;
  localparam int ns = fetch_pkg::num_super;

  logic [aw-1:0]                  pc;
  logic [aw-1:0]                  next_pc;
  fetch_pkg::branch_fmt_t [ns-1:0] br;
  logic [ns-1:0]                  taken;
  logic [ns-1:0][aw-1:0]          offset;

  assign pair_addr = {pc[aw-1:3], 3'b000};
  assign br = rd_data;  // words seen in branch form

  always_comb begin
    for (int i = 0; i < ns; i++) begin
      // backward conditional branch predicted taken
      taken[i] = fetch_pkg::is_cond_branch(br[i].opcode) & br[i].disp[20];
      offset[i] = {{(aw - 23){br[i].disp[20]}}, br[i].disp, 2'b00};
      pair.pc[i] = pair_addr + aw'(4 * i);
      pair.npc[i] = pair.pc[i] + aw'(4);
      pair.inst[i] = rd_data[i];
      if (taken[i]) begin
        pair.target[i] = pair.npc[i] + offset[i];
      end else begin
        pair.target[i] = pair.npc[i];
      end
    end
    pair.valid[0] = ~pc[2];  // odd start skips slot 0
    pair.valid[1] = ~(pair.valid[0] & taken[0]);
  end

  // successor of the last valid slot
  assign next_pc = pair.valid[1] ? pair.target[1] : pair.target[0];

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (redirect) begin
      pc <= redirect_pc;  // redirect wins over fetch
    end else if (fetch_en) begin
      pc <= next_pc;
    end
  end

endmodule

//--- verilog/fetch_buffer.sv
`timescale 1ns/10ps

module fetch_buffer #(
  parameter int fb_entries = 8
) (
  input  logic                       clock,
  input  logic                       rst,
  input  fetch_pkg::fetch_pair_t     pair,
  input  logic                       get_next_inst,
  input  logic                       rollback_en,
  output fetch_pkg::fb_decoder_out_t decoder_out,
  output logic                       inst_out_valid,
  output logic                       fetch_en
);

  localparam int ptr_w = $clog2(fb_entries);
  localparam int ns = fetch_pkg::num_super;

  fetch_pkg::fetch_entry_t [fb_entries-1:0] fb;
  fetch_pkg::fetch_entry_t [fb_entries-1:0] nfb;
  fetch_pkg::fetch_entry_t [ns-1:0]         in_entry;
  logic [ptr_w-1:0]                         head;
  logic [ptr_w-1:0]                         tail;
  logic [ptr_w-1:0]                         head_plus_one;
  logic [ptr_w-1:0]                         head_plus_two;
  logic [ptr_w-1:0]                         tail_plus_one;
  logic [ptr_w-1:0]                         tail_plus_two;
  logic [ptr_w-1:0]                         next_head;
  logic [ptr_w-1:0]                         next_tail;
  logic                                     one_in;
  logic                                     two_in;

  assign head_plus_one = head + 1'b1;
  assign head_plus_two = head + 2'd2;
  assign tail_plus_one = tail + 1'b1;
  assign tail_plus_two = tail + 2'd2;

  assign one_in = pair.valid == 2'b01 || pair.valid == 2'b10;
  assign two_in = pair.valid == 2'b11;

  // room for every valid slot, none on rollback
  assign fetch_en = ((one_in & ~fb[head].valid) |
                     (two_in & ~fb[head].valid & ~fb[head_plus_one].valid)) & ~rollback_en;

  assign inst_out_valid = fb[tail].valid & fb[tail_plus_one].valid;

  assign decoder_out.pc     = {fb[tail_plus_one].pc, fb[tail].pc};
  assign decoder_out.npc    = {fb[tail_plus_one].npc, fb[tail].npc};
  assign decoder_out.inst   = {fb[tail_plus_one].inst, fb[tail].inst};
  assign decoder_out.target = {fb[tail_plus_one].target, fb[tail].target};
  assign decoder_out.valid  = inst_out_valid;

  always_comb begin
    for (int i = 0; i < ns; i++) begin
      in_entry[i].pc = pair.pc[i];
      in_entry[i].npc = pair.npc[i];
      in_entry[i].target = pair.target[i];
      in_entry[i].inst = pair.inst[i];
      in_entry[i].valid = pair.valid[i];
    end
  end

  assign next_head = (fetch_en & two_in) ? head_plus_two :
                     (fetch_en & one_in) ? head_plus_one : head;
  assign next_tail = get_next_inst ? tail_plus_two : tail;

  always_comb begin
    nfb = fb;
    if (fetch_en) begin
      if (two_in) begin
        nfb[head] = in_entry[0];
        nfb[head_plus_one] = in_entry[1];
      end else if (pair.valid[0]) begin
        nfb[head] = in_entry[0];
      end else begin
        nfb[head] = in_entry[1];  // odd start
      end
    end
    if (get_next_inst) begin
      nfb[tail].valid = 1'b0;
      nfb[tail_plus_one].valid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rst | rollback_en) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < fb_entries; i++) begin
        fb[i].pc <= fetch_pkg::poison_pc;
        fb[i].npc <= fetch_pkg::poison_pc;
        fb[i].target <= fetch_pkg::poison_pc;
        fb[i].inst <= fetch_pkg::noop_inst;
        fb[i].valid <= 1'b0;
      end
    end else begin
      fb <= nfb;
      head <= next_head;
      tail <= next_tail;
    end
  end

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/10ps

module fetch_top #(
  parameter int                           mem_words  = 256,
  parameter int                           fb_entries = 8,
  parameter logic [fetch_pkg::addr_w-1:0] reset_pc   = '0
) (
  input  logic                               clock,
  input  logic                               rst,
  input  logic                               load,
  input  logic [$clog2(mem_words)-1:0]       load_addr,
  input  logic [fetch_pkg::inst_w-1:0]       load_data,
  input  logic                               redirect,
  input  logic [fetch_pkg::addr_w-1:0]       redirect_pc,
  input  logic                               get_next_inst,
  output fetch_pkg::fb_decoder_out_t         decoder_out,
  output logic                               inst_out_valid,
  output logic                               fetch_en
);

  logic [fetch_pkg::addr_w-1:0]                           pair_addr;
  logic [fetch_pkg::num_super-1:0][fetch_pkg::inst_w-1:0] rd_data;
  fetch_pkg::fetch_pair_t                                 pair;

  inst_mem #(.mem_words(mem_words)) u_mem (
    .clock, .load, .load_addr, .load_data, .pair_addr, .rd_data
  );

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clock, .rst, .redirect, .redirect_pc, .fetch_en, .rd_data, .pair_addr, .pair
  );

  fetch_buffer #(.fb_entries(fb_entries)) u_fb (
    .clock,
    .rst,
    .pair,
    .get_next_inst,
    .rollback_en    (redirect),  // redirect flushes the buffer
    .decoder_out,
    .inst_out_valid,
    .fetch_en
  );

endmodule

//--- bench/fetch_assertions.sv
`timescale 1ns/10ps

module fetch_assertions #(
  parameter int          mem_words = 256,
  parameter logic [63:0] reset_pc  = '0
) (
  input logic                         clock,
  input logic                         rst,
  input logic                         load,
  input logic [$clog2(mem_words)-1:0] load_addr,
  input logic [31:0]                  load_data,
  input logic                         redirect,
  input logic [63:0]                  redirect_pc,
  input logic                         get_next_inst,
  input fetch_pkg::fb_decoder_out_t   decoder_out,
  input logic                         inst_out_valid,
  input logic                         fetch_en
);

  localparam int idx_w = $clog2(mem_words);
  localparam int stall_after = 16;  // buffer is full well before this

  logic [31:0]                mem_copy [mem_words];
  logic [63:0]                exp_pc;  // slot 0 pc of next pair
  logic                       take;
  bit                         armed;
  bit                         rst_prev;
  bit                         redirect_prev;
  bit                         hold_prev;
  fetch_pkg::fb_decoder_out_t prev_out;
  int unsigned                idle_cycles;
  int unsigned                fail_count = 0;

  function automatic logic [31:0] word_at(logic [63:0] pc);
    return mem_copy[pc[idx_w+1:2]];
  endfunction

  // backward conditional branch taken, all else falls through
  function automatic logic [63:0] predict_target(logic [63:0] pc, logic [31:0] inst);
    logic [20:0] disp;
    logic [63:0] fall_through;
    disp = inst[20:0];
    fall_through = pc + 64'd4;
    if (inst[31:26] >= 6'h38 && disp[20]) begin
      return fall_through + {{41{disp[20]}}, disp, 2'b00};
    end
    return fall_through;
  endfunction

  assign take = inst_out_valid & get_next_inst;

  always_ff @(posedge clock) begin
    if (load) begin
      mem_copy[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      armed <= 1'b1;
      exp_pc <= reset_pc;
      idle_cycles <= 0;
    end else begin
      if (redirect) begin
        exp_pc <= redirect_pc;
      end else if (take) begin
        exp_pc <= decoder_out.target[1];  // chain continues from slot 1
      end
      if (get_next_inst | redirect) begin
        idle_cycles <= 0;
      end else if (idle_cycles < 1000) begin
        idle_cycles <= idle_cycles + 1;
      end
    end
  end

  always_ff @(posedge clock) begin
    rst_prev <= rst;
    redirect_prev <= redirect & ~rst;
    hold_prev <= inst_out_valid & ~get_next_inst & ~redirect & ~rst;
    prev_out <= decoder_out;
  end

  a_reset_state: assert property (@(posedge clock) rst_prev && !rst |-> !inst_out_valid && fetch_en)
    else begin
      fail_count++;
      $error("ERR %0t inst_out_valid,fetch_en expected 0,1 actual %b,%b", $time,
             $sampled(inst_out_valid), $sampled(fetch_en));
    end

  a_start_pc: assert property (@(posedge clock) disable iff (rst || !armed)
    take |-> decoder_out.pc[0] == exp_pc)
    else begin
      fail_count++;
      $error("ERR %0t decoder_out.pc[0] expected %h actual %h", $time,
             $sampled(exp_pc), $sampled(decoder_out.pc[0]));
    end

  a_order: assert property (@(posedge clock) disable iff (rst || !armed)
    take |-> decoder_out.pc[1] == decoder_out.target[0])
    else begin
      fail_count++;
      $error("ERR %0t decoder_out.pc[1] expected %h actual %h", $time,
             $sampled(decoder_out.target[0]), $sampled(decoder_out.pc[1]));
    end

  a_redirect_clear: assert property (@(posedge clock) disable iff (rst || !armed)
    redirect_prev |-> !inst_out_valid)
    else begin
      fail_count++;
      $error("ERR %0t inst_out_valid expected 0 actual %b", $time, $sampled(inst_out_valid));
    end

  a_stall: assert property (@(posedge clock) disable iff (rst || !armed)
    idle_cycles >= stall_after |-> !fetch_en)
    else begin
      fail_count++;
      $error("ERR %0t fetch_en expected 0 actual %b", $time, $sampled(fetch_en));
    end

  a_stable: assert property (@(posedge clock) disable iff (rst || !armed)
    hold_prev |-> decoder_out == prev_out)
    else begin
      fail_count++;
      $error("ERR %0t decoder_out expected %h actual %h", $time,
             $sampled(prev_out), $sampled(decoder_out));
    end

  for (genvar s = 0; s < 2; s++) begin : g_slot
    a_npc: assert property (@(posedge clock) disable iff (rst || !armed)
      take |-> decoder_out.npc[s] == decoder_out.pc[s] + 64'd4)
      else begin
        fail_count++;
        $error("ERR %0t decoder_out.npc[%0d] expected %h actual %h", $time, s,
               $sampled(decoder_out.pc[s]) + 64'd4, $sampled(decoder_out.npc[s]));
      end

    a_target: assert property (@(posedge clock) disable iff (rst || !armed)
      take |-> decoder_out.target[s] == predict_target(decoder_out.pc[s], decoder_out.inst[s]))
      else begin
        fail_count++;
        $error("ERR %0t decoder_out.target[%0d] expected %h actual %h", $time, s,
               predict_target($sampled(decoder_out.pc[s]), $sampled(decoder_out.inst[s])),
               $sampled(decoder_out.target[s]));
      end

    a_inst: assert property (@(posedge clock) disable iff (rst || !armed)
      take |-> decoder_out.inst[s] == word_at(decoder_out.pc[s]))
      else begin
        fail_count++;
        $error("ERR %0t decoder_out.inst[%0d] expected %h actual %h", $time, s,
               word_at($sampled(decoder_out.pc[s])), $sampled(decoder_out.inst[s]));
      end
  end

endmodule

//--- bench/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;

  localparam int mem_words = 256;
  localparam int num_phases = 3;
  localparam int cycle_limit = mem_words + 400 * num_phases;

  logic                         clock;
  logic                         rst;
  logic                         load;
  logic [$clog2(mem_words)-1:0] load_addr;
  logic [31:0]                  load_data;
  logic                         redirect;
  logic [63:0]                  redirect_pc;
  logic                         get_next_inst;
  fetch_pkg::fb_decoder_out_t   decoder_out;
  logic                         inst_out_valid;
  logic                         fetch_en;

  int unsigned cycle_count = 0;
  int unsigned timeouts = 0;
  int unsigned seed;

  fetch_top #(
    .mem_words (mem_words),
    .fb_entries(8),
    .reset_pc  ('0)
  ) DUT (
    .clock, .rst, .load, .load_addr, .load_data, .redirect, .redirect_pc,
    .get_next_inst, .decoder_out, .inst_out_valid, .fetch_en
  );

  bind fetch_top fetch_assertions #(
    .mem_words(mem_words),
    .reset_pc (reset_pc)
  ) checks (
    .clock, .rst, .load, .load_addr, .load_data, .redirect, .redirect_pc,
    .get_next_inst, .decoder_out, .inst_out_valid, .fetch_en
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // mix of plain words, forward branches and short backward loops
  function automatic logic [31:0] make_word(int idx);
    int unsigned kind;
    int unsigned reach;
    logic [5:0]  opcode;
    logic [20:0] disp;
    kind = $urandom % 16;
    opcode = 6'h38 + 6'($urandom % 8);
    if (kind == 0 && idx > 0) begin
      reach = (idx < 12) ? idx : 12;
      disp = 21'(-1 - int'($urandom % reach));  // target stays at or above word 0
    end else if (kind <= 2) begin
      disp = 21'(1 + $urandom % 16);
    end else begin
      opcode = 6'($urandom % 56);  // below the branch opcodes
      disp = 21'($urandom);
    end
    return {opcode, 5'($urandom), disp};
  endfunction

  task automatic load_program();
    for (int w = 0; w < mem_words; w++) begin
      @(posedge clock);
      #2;
      load = 1'b1;
      load_addr = w[$clog2(mem_words)-1:0];
      load_data = make_word(w);
    end
    @(posedge clock);
    #2;
    load = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #2;
    rst = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    rst = 1'b0;
  endtask

  task automatic consume_pairs(input int unsigned count);
    int unsigned taken;
    taken = 0;
    while (taken < count) begin
      @(posedge clock);
      #2;
      get_next_inst = inst_out_valid;  // only take a full pair
      if (inst_out_valid) begin
        taken++;
      end
    end
    @(posedge clock);
    #2;
    get_next_inst = 1'b0;
  endtask

  task automatic hold_consumer(input int unsigned cycles);
    get_next_inst = 1'b0;
    repeat (cycles) @(posedge clock);
  endtask

  task automatic send_redirect(input logic [63:0] pc);
    @(posedge clock);
    #2;
    redirect = 1'b1;
    redirect_pc = pc;
    @(posedge clock);
    #2;
    redirect = 1'b0;
  endtask

  task automatic finish_run();
    int unsigned fails;
    fails = DUT.checks.fail_count;
    $display("assertion failures: %0d  timeouts: %0d", fails, timeouts);
    if (fails == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  initial begin : watchdog
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    timeouts++;
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    finish_run();
  end

  initial begin
    seed = $urandom(36422);
    rst = 1'b0;
    load = 1'b0;
    load_addr = '0;
    load_data = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    get_next_inst = 1'b0;
    load_program();
    apply_reset();
    consume_pairs(40);  // from reset_pc
    hold_consumer(30);  // buffer fills, fetch stalls
    consume_pairs(10);
    send_redirect(64'd404);  // odd word, slot 0 skipped
    consume_pairs(30);
    send_redirect(64'((2 * ($urandom % 128) + 1) * 4));
    consume_pairs(20);
    finish_run();
  end

endmodule

//--- files.f
verilog/fetch_pkg.sv
verilog/inst_mem.sv
verilog/fetch_stage.sv
verilog/fetch_buffer.sv
verilog/fetch_top.sv
bench/fetch_assertions.sv
bench/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -f files.f -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
